// File: src/mips16_pkg.sv
package mips16_pkg;

        localparam int inst_w    = 16;
        localparam int data_w    = 16;
        localparam int reg_idx_w = 3;
        localparam int op_w      = 5;   // Major opcode width, bits 15..11.

        localparam logic [op_w-1:0] op_addsp3 = 5'b00000;
        localparam logic [op_w-1:0] op_nop    = 5'b00001;
        localparam logic [op_w-1:0] op_b      = 5'b00010;
        localparam logic [op_w-1:0] op_beqz   = 5'b00100;
        localparam logic [op_w-1:0] op_bnez   = 5'b00101;
        localparam logic [op_w-1:0] op_group5 = 5'b00110;   // Immediate shifts.
        localparam logic [op_w-1:0] op_addiu3 = 5'b01000;
        localparam logic [op_w-1:0] op_addiu  = 5'b01001;
        localparam logic [op_w-1:0] op_group1 = 5'b01100;
        localparam logic [op_w-1:0] op_li     = 5'b01101;
        localparam logic [op_w-1:0] op_cmpi   = 5'b01110;
        localparam logic [op_w-1:0] op_lw_sp  = 5'b10010;
        localparam logic [op_w-1:0] op_lw     = 5'b10011;
        localparam logic [op_w-1:0] op_sw_sp  = 5'b11010;
        localparam logic [op_w-1:0] op_sw     = 5'b11011;
        localparam logic [op_w-1:0] op_group2 = 5'b11100;   // Three-register add and subtract.
        localparam logic [op_w-1:0] op_group3 = 5'b11101;
        localparam logic [op_w-1:0] op_group4 = 5'b11110;   // Moves to and from IH.

        // Every enumeration puts its idle value at zero.
        typedef enum logic [4:0] {
                ctl_nop, ctl_addiu, ctl_addiu3, ctl_addsp, ctl_addsp3,
                ctl_addu, ctl_subu, ctl_and, ctl_or, ctl_cmp, ctl_cmpi,
                ctl_sll, ctl_sllv, ctl_sra, ctl_srl,
                ctl_b, ctl_beqz, ctl_bnez, ctl_bteqz, ctl_jr,
                ctl_li, ctl_lw, ctl_lw_sp, ctl_sw, ctl_sw_sp, ctl_sw_rs,
                ctl_mfih, ctl_mtih, ctl_mfpc, ctl_mtsp
        } ctl_op_e;

        typedef enum logic [3:0] {
                alu_nop, alu_add, alu_sub, alu_and, alu_or, alu_equ,
                alu_sll, alu_sllv, alu_sra, alu_srl, alu_reta, alu_retb
        } alu_op_e;

        typedef enum logic [2:0] {asel_nop, asel_rega, asel_sp, asel_t, asel_rz} alu_a_sel_e;
        typedef enum logic [1:0] {bsel_nop, bsel_regb, bsel_im} alu_b_sel_e;
        typedef enum logic [2:0] {dst_nop, dst_reg, dst_sp, dst_t, dst_ih} reg_dst_e;
        typedef enum logic [2:0] {wb_nop, wb_alu, wb_mem, wb_ih, wb_pc} wb_src_e;
        typedef enum logic [1:0] {fld_nop, fld_rx, fld_ry, fld_rz} wb_field_e;
        typedef enum logic [1:0] {jmp_nop, jmp_always, jmp_zero, jmp_nonzero} jump_mode_e;
        typedef enum logic [1:0] {jsrc_nop, jsrc_rel, jsrc_alu} jump_src_e;   // Rel is PC plus imm.
        typedef enum logic [1:0] {st_nop, st_rega, st_regb, st_ra} st_src_e;

        typedef enum logic [2:0] {
                imm_none, imm_s3_0, imm_s4_0, imm_s7_0, imm_z7_0, imm_s10_0
        } imm_fmt_e;

        typedef struct packed {
                logic [op_w-1:0]      op;
                logic [reg_idx_w-1:0] rx;
                logic [reg_idx_w-1:0] ry;
                logic [reg_idx_w-1:0] rz;
                logic [1:0]           funct2;
        } inst_rrr_s;

        typedef struct packed {
                logic [op_w-1:0]        op;
                logic [inst_w-op_w-1:0] imm11;
        } inst_imm_s;

        // The register fields overlap the immediate, so the decoder reads the word both ways.
        typedef union packed {
                inst_rrr_s rrr;
                inst_imm_s imm;
        } inst_word_u;

        typedef struct packed {
                alu_op_e    alu_op;
                alu_a_sel_e alu_a_sel;
                alu_b_sel_e alu_b_sel;
                reg_dst_e   reg_dst;
                wb_src_e    wb_src;
                wb_field_e  wb_field;
                logic       mem_en;
                logic       mem_wr;     // High for a store, low for a load.
                jump_mode_e jump_mode;
                jump_src_e  jump_src;
                imm_fmt_e   imm_fmt;
                st_src_e    st_src;
        } ctrl_s;

        localparam ctrl_s ctrl_nop = '{
                alu_op: alu_nop, alu_a_sel: asel_nop, alu_b_sel: bsel_nop,
                reg_dst: dst_nop, wb_src: wb_nop, wb_field: fld_nop,
                mem_en: 1'b0, mem_wr: 1'b0, jump_mode: jmp_nop,
                jump_src: jsrc_nop, imm_fmt: imm_none, st_src: st_nop
        };

        typedef struct packed {
                ctrl_s                ctrl;
                logic [data_w-1:0]    imm;
                logic [reg_idx_w-1:0] wb_reg;
        } decode_out_s;

endpackage

// File: src/inst_classify.sv
`timescale 1ns/10ps

module inst_classify
        import mips16_pkg::*;
(
        input  inst_word_u inst,
        output ctl_op_e    ctl_op
);

        logic [4:0] low5;       // Group3 sub-function, the rz and funct2 fields.

        assign low5 = {inst.rrr.rz, inst.rrr.funct2};

        always_comb begin
                ctl_op = ctl_nop;       // Unmatched words and sub-functions fall through.
                case (inst.rrr.op)
                        op_addsp3: ctl_op = ctl_addsp3;
                        op_nop:    ctl_op = ctl_nop;
                        op_b:      ctl_op = ctl_b;
                        op_beqz:   ctl_op = ctl_beqz;
                        op_bnez:   ctl_op = ctl_bnez;
                        op_addiu3: ctl_op = ctl_addiu3;
                        op_addiu:  ctl_op = ctl_addiu;
                        op_li:     ctl_op = ctl_li;
                        op_cmpi:   ctl_op = ctl_cmpi;
                        op_lw_sp:  ctl_op = ctl_lw_sp;
                        op_lw:     ctl_op = ctl_lw;
                        op_sw_sp:  ctl_op = ctl_sw_sp;
                        op_sw:     ctl_op = ctl_sw;
                        op_group1: begin
                                case (inst.rrr.rx)
                                        3'b000:  ctl_op = ctl_bteqz;
                                        3'b010:  ctl_op = ctl_sw_rs;
                                        3'b011:  ctl_op = ctl_addsp;
                                        3'b100:  ctl_op = ctl_mtsp;
                                        default: ;
                                endcase
                        end
                        op_group2: begin
                                case (inst.rrr.funct2)
                                        2'b01:   ctl_op = ctl_addu;
                                        2'b11:   ctl_op = ctl_subu;
                                        default: ;
                                endcase
                        end
                        op_group3: begin
                                case (low5)
                                        5'b01100: ctl_op = ctl_and;
                                        5'b01010: ctl_op = ctl_cmp;
                                        5'b01101: ctl_op = ctl_or;
                                        5'b00100: ctl_op = ctl_sllv;
                                        5'b00000: begin
                                                // JR and MFPC share a sub-function and differ in ry.
                                                if (inst.rrr.ry == 3'b000) begin
                                                        ctl_op = ctl_jr;
                                                end else if (inst.rrr.ry == 3'b010) begin
                                                        ctl_op = ctl_mfpc;
                                                end
                                        end
                                        default: ;
                                endcase
                        end
                        op_group4: ctl_op = inst.rrr.funct2[0] ? ctl_mtih : ctl_mfih;
                        op_group5: begin
                                case (inst.rrr.funct2)
                                        2'b00:   ctl_op = ctl_sll;
                                        2'b11:   ctl_op = ctl_sra;
                                        2'b10:   ctl_op = ctl_srl;
                                        default: ;
                                endcase
                        end
                        default: ;
                endcase
        end

endmodule

// File: src/ctrl_table.sv
`timescale 1ns/10ps

module ctrl_table
        import mips16_pkg::*;
(
        input  ctl_op_e ctl_op,
        output ctrl_s   ctrl
);

        // The table is kept by field, each case naming only the operations that leave NOP.
        always_comb begin
                ctrl = ctrl_nop;

                case (ctl_op)
                        ctl_addiu, ctl_addiu3, ctl_addsp, ctl_addsp3, ctl_addu,
                        ctl_lw, ctl_lw_sp, ctl_sw, ctl_sw_sp, ctl_sw_rs: ctrl.alu_op = alu_add;
                        ctl_subu:         ctrl.alu_op = alu_sub;
                        ctl_and:          ctrl.alu_op = alu_and;
                        ctl_or:           ctrl.alu_op = alu_or;
                        ctl_cmp, ctl_cmpi: ctrl.alu_op = alu_equ;   // Result lands in T.
                        ctl_sll:          ctrl.alu_op = alu_sll;
                        ctl_sllv:         ctrl.alu_op = alu_sllv;
                        ctl_sra:          ctrl.alu_op = alu_sra;
                        ctl_srl:          ctrl.alu_op = alu_srl;
                        ctl_jr, ctl_mtih: ctrl.alu_op = alu_reta;
                        ctl_li, ctl_mtsp: ctrl.alu_op = alu_retb;
                        default: ;
                endcase

                case (ctl_op)
                        ctl_addiu, ctl_addiu3, ctl_addu, ctl_subu, ctl_and, ctl_or,
                        ctl_cmp, ctl_cmpi, ctl_sllv, ctl_beqz, ctl_bnez, ctl_jr,
                        ctl_mtih, ctl_lw, ctl_sw: ctrl.alu_a_sel = asel_rega;
                        ctl_addsp, ctl_addsp3, ctl_lw_sp, ctl_sw_sp, ctl_sw_rs:
                                ctrl.alu_a_sel = asel_sp;
                        ctl_bteqz:                 ctrl.alu_a_sel = asel_t;
                        ctl_sll, ctl_sra, ctl_srl: ctrl.alu_a_sel = asel_rz;
                        default: ;
                endcase

                case (ctl_op)
                        ctl_addiu, ctl_addiu3, ctl_addsp, ctl_addsp3, ctl_cmpi, ctl_li,
                        ctl_lw, ctl_lw_sp, ctl_sw, ctl_sw_sp, ctl_sw_rs: ctrl.alu_b_sel = bsel_im;
                        ctl_addu, ctl_subu, ctl_and, ctl_or, ctl_cmp, ctl_sllv,
                        ctl_sll, ctl_sra, ctl_srl, ctl_mtsp: ctrl.alu_b_sel = bsel_regb;
                        default: ;
                endcase

                case (ctl_op)
                        ctl_addiu, ctl_addiu3, ctl_addsp3, ctl_addu, ctl_subu, ctl_and,
                        ctl_or, ctl_sll, ctl_sllv, ctl_sra, ctl_srl, ctl_li,
                        ctl_lw, ctl_lw_sp, ctl_mfih, ctl_mfpc: ctrl.reg_dst = dst_reg;
                        ctl_addsp, ctl_mtsp: ctrl.reg_dst = dst_sp;
                        ctl_cmp, ctl_cmpi:   ctrl.reg_dst = dst_t;
                        ctl_mtih:            ctrl.reg_dst = dst_ih;
                        default: ;
                endcase

                case (ctl_op)
                        ctl_addiu, ctl_addiu3, ctl_addsp, ctl_addsp3, ctl_addu, ctl_subu,
                        ctl_and, ctl_or, ctl_cmp, ctl_cmpi, ctl_sll, ctl_sllv, ctl_sra,
                        ctl_srl, ctl_li, ctl_mtih, ctl_mtsp: ctrl.wb_src = wb_alu;
                        ctl_lw, ctl_lw_sp: ctrl.wb_src = wb_mem;
                        ctl_mfih:          ctrl.wb_src = wb_ih;
                        ctl_mfpc:          ctrl.wb_src = wb_pc;
                        default: ;
                endcase

                case (ctl_op)
                        ctl_addiu, ctl_addsp3, ctl_and, ctl_or, ctl_sll, ctl_sra, ctl_srl,
                        ctl_li, ctl_lw_sp, ctl_mfih, ctl_mfpc: ctrl.wb_field = fld_rx;
                        ctl_addiu3, ctl_sllv, ctl_lw: ctrl.wb_field = fld_ry;
                        ctl_addu, ctl_subu:           ctrl.wb_field = fld_rz;
                        default: ;
                endcase

                case (ctl_op)
                        ctl_lw, ctl_lw_sp: ctrl.mem_en = 1'b1;
                        ctl_sw, ctl_sw_sp, ctl_sw_rs: begin
                                ctrl.mem_en = 1'b1;
                                ctrl.mem_wr = 1'b1;
                        end
                        default: ;
                endcase

                case (ctl_op)
                        ctl_sw:    ctrl.st_src = st_regb;
                        ctl_sw_sp: ctrl.st_src = st_rega;
                        ctl_sw_rs: ctrl.st_src = st_ra;
                        default: ;
                endcase

                case (ctl_op)
                        ctl_b, ctl_jr:        ctrl.jump_mode = jmp_always;
                        ctl_beqz, ctl_bteqz:  ctrl.jump_mode = jmp_zero;
                        ctl_bnez:             ctrl.jump_mode = jmp_nonzero;
                        default: ;
                endcase
                if (ctl_op inside {ctl_b, ctl_beqz, ctl_bnez, ctl_bteqz}) begin
                        ctrl.jump_src = jsrc_rel;
                end else if (ctl_op == ctl_jr) begin
                        ctrl.jump_src = jsrc_alu;       // Target comes back through the ALU.
                end

                case (ctl_op)
                        ctl_addiu3:     ctrl.imm_fmt = imm_s3_0;
                        ctl_lw, ctl_sw: ctrl.imm_fmt = imm_s4_0;
                        ctl_addiu, ctl_addsp, ctl_addsp3, ctl_beqz, ctl_bnez, ctl_bteqz,
                        ctl_cmpi, ctl_lw_sp, ctl_sw_sp, ctl_sw_rs: ctrl.imm_fmt = imm_s7_0;
                        ctl_li:         ctrl.imm_fmt = imm_z7_0;
                        ctl_b:          ctrl.imm_fmt = imm_s10_0;
                        default: ;
                endcase

                // A store never also names a register class to write back into.
                assert (!(ctrl.mem_en && ctrl.mem_wr) || ctrl.reg_dst == dst_nop);
        end

endmodule

// File: src/operand_fields.sv
`timescale 1ns/10ps

module operand_fields
        import mips16_pkg::*;
(
        input  inst_word_u           inst,
        input  ctrl_s                ctrl,
        output logic [data_w-1:0]    imm,
        output logic [reg_idx_w-1:0] wb_reg
);

        logic [inst_w-op_w-1:0] f;

        assign f = inst.imm.imm11;

        // A signed cast before the width cast gives sign extension.
        always_comb begin
                case (ctrl.imm_fmt)
                        imm_s3_0:  imm = data_w'(signed'(f[3:0]));
                        imm_s4_0:  imm = data_w'(signed'(f[4:0]));
                        imm_s7_0:  imm = data_w'(signed'(f[7:0]));
                        imm_z7_0:  imm = data_w'(f[7:0]);
                        imm_s10_0: imm = data_w'(signed'(f[10:0]));
                        default:   imm = '0;
                endcase
        end

        always_comb begin
                case (ctrl.wb_field)
                        fld_rx:  wb_reg = inst.rrr.rx;
                        fld_ry:  wb_reg = inst.rrr.ry;
                        fld_rz:  wb_reg = inst.rrr.rz;
                        default: wb_reg = '0;   // No register write.
                endcase
        end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
        import mips16_pkg::*;
(
        input  logic        clk_50mhz,
        input  logic        rst_n,
        input  logic        in_valid,
        input  inst_word_u  inst,
        output logic        out_valid,
        output decode_out_s out
);

        ctl_op_e              ctl_op;
        ctrl_s                ctrl;
        logic [data_w-1:0]    imm;
        logic [reg_idx_w-1:0] wb_reg;

        inst_classify u_classify (
                .inst   (inst),
                .ctl_op (ctl_op)
        );

        ctrl_table u_table (
                .ctl_op (ctl_op),
                .ctrl   (ctrl)
        );

        operand_fields u_fields (
                .inst   (inst),
                .ctrl   (ctrl),
                .imm    (imm),
                .wb_reg (wb_reg)
        );

        always_ff @(posedge clk_50mhz) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                        out       <= '{ctrl: ctrl_nop, imm: '0, wb_reg: '0};
                end else begin
                        out_valid <= in_valid;
                        if (in_valid) begin
                                out <= '{ctrl: ctrl, imm: imm, wb_reg: wb_reg};
                        end
                end
        end

        // Each accepted word shows up exactly one edge later.
        valid_latency: assert property (@(posedge clk_50mhz)
                $past(rst_n) |-> out_valid == $past(in_valid));

        // Coming out of reset the stage presents an idle NOP.
        reset_idle: assert property (@(posedge clk_50mhz)
                rst_n && !$past(rst_n) |-> !out_valid && !out.ctrl.mem_en);

endmodule

// File: include/decode_vectors.svh
// Columns: instruction word, expected control bundle, expected imm, expected wb_reg.
// The bundle order is alu_op, alu_a_sel, alu_b_sel, reg_dst, wb_src, wb_field,
// mem_en, mem_wr, jump_mode, jump_src, imm_fmt, st_src.
task automatic load_vectors();
        add_vec(16'hE14D, '{alu_add, asel_rega, bsel_regb, dst_reg, wb_alu, fld_rz,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd3);   // ADDU.
        add_vec(16'hE4BB, '{alu_sub, asel_rega, bsel_regb, dst_reg, wb_alu, fld_rz,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd6);   // SUBU.
        add_vec(16'hEA6C, '{alu_and, asel_rega, bsel_regb, dst_reg, wb_alu, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd2);   // AND.
        add_vec(16'hED2D, '{alu_or, asel_rega, bsel_regb, dst_reg, wb_alu, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd5);   // OR.
        add_vec(16'hEB8A, '{alu_equ, asel_rega, bsel_regb, dst_t, wb_alu, fld_nop,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd0);   // CMP.
        add_vec(16'h74F0, '{alu_equ, asel_rega, bsel_im, dst_t, wb_alu, fld_nop,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_s7_0, st_nop}, 16'hFFF0, 3'd0);   // CMPI.
        add_vec(16'h3154, '{alu_sll, asel_rz, bsel_regb, dst_reg, wb_alu, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd1);   // SLL.
        add_vec(16'h3267, '{alu_sra, asel_rz, bsel_regb, dst_reg, wb_alu, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd2);   // SRA.
        add_vec(16'h370A, '{alu_srl, asel_rz, bsel_regb, dst_reg, wb_alu, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd7);   // SRL.
        add_vec(16'hEBC4, '{alu_sllv, asel_rega, bsel_regb, dst_reg, wb_alu, fld_ry,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd6);   // SLLV.
        add_vec(16'h6BA5, '{alu_retb, asel_nop, bsel_im, dst_reg, wb_alu, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_z7_0, st_nop}, 16'h00A5, 3'd3);   // LI.
        add_vec(16'h4A80, '{alu_add, asel_rega, bsel_im, dst_reg, wb_alu, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_s7_0, st_nop}, 16'hFF80, 3'd2);   // ADDIU.
        add_vec(16'h4189, '{alu_add, asel_rega, bsel_im, dst_reg, wb_alu, fld_ry,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_s3_0, st_nop}, 16'hFFF9, 3'd4);   // ADDIU3.
        add_vec(16'hF500, '{alu_nop, asel_nop, bsel_nop, dst_reg, wb_ih, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd5);   // MFIH.
        add_vec(16'hF601, '{alu_reta, asel_rega, bsel_nop, dst_ih, wb_alu, fld_nop,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd0);   // MTIH.
        add_vec(16'hEC40, '{alu_nop, asel_nop, bsel_nop, dst_reg, wb_pc, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd4);   // MFPC.
        add_vec(16'h6460, '{alu_retb, asel_nop, bsel_regb, dst_sp, wb_alu, fld_nop,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_none, st_nop}, 16'h0000, 3'd0);   // MTSP.
        add_vec(16'h637F, '{alu_add, asel_sp, bsel_im, dst_sp, wb_alu, fld_nop,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_s7_0, st_nop}, 16'h007F, 3'd0);   // ADDSP.
        add_vec(16'h02FE, '{alu_add, asel_sp, bsel_im, dst_reg, wb_alu, fld_rx,
                1'b0, 1'b0, jmp_nop, jsrc_nop, imm_s7_0, st_nop}, 16'hFFFE, 3'd2);   // ADDSP3.
        add_vec(16'h9953, '{alu_add, asel_rega, bsel_im, dst_reg, wb_mem, fld_ry,
                1'b1, 1'b0, jmp_nop, jsrc_nop, imm_s4_0, st_nop}, 16'hFFF3, 3'd2);   // LW.
        add_vec(16'h9305, '{alu_add, asel_sp, bsel_im, dst_reg, wb_mem, fld_rx,
                1'b1, 1'b0, jmp_nop, jsrc_nop, imm_s7_0, st_nop}, 16'h0005, 3'd3);   // LW_SP.
        add_vec(16'hDCAF, '{alu_add, asel_rega, bsel_im, dst_nop, wb_nop, fld_nop,
                1'b1, 1'b1, jmp_nop, jsrc_nop, imm_s4_0, st_regb}, 16'h000F, 3'd0);  // SW.
        add_vec(16'hD281, '{alu_add, asel_sp, bsel_im, dst_nop, wb_nop, fld_nop,
                1'b1, 1'b1, jmp_nop, jsrc_nop, imm_s7_0, st_rega}, 16'hFF81, 3'd0);  // SW_SP.
        add_vec(16'h6210, '{alu_add, asel_sp, bsel_im, dst_nop, wb_nop, fld_nop,
                1'b1, 1'b1, jmp_nop, jsrc_nop, imm_s7_0, st_ra}, 16'h0010, 3'd0);    // SW_RS.
        add_vec(16'h1400, '{alu_nop, asel_nop, bsel_nop, dst_nop, wb_nop, fld_nop,
                1'b0, 1'b0, jmp_always, jsrc_rel, imm_s10_0, st_nop}, 16'hFC00, 3'd0);
        add_vec(16'h1123, '{alu_nop, asel_nop, bsel_nop, dst_nop, wb_nop, fld_nop,
                1'b0, 1'b0, jmp_always, jsrc_rel, imm_s10_0, st_nop}, 16'h0123, 3'd0);
        add_vec(16'h21FC, '{alu_nop, asel_rega, bsel_nop, dst_nop, wb_nop, fld_nop,
                1'b0, 1'b0, jmp_zero, jsrc_rel, imm_s7_0, st_nop}, 16'hFFFC, 3'd0);  // BEQZ.
        add_vec(16'h2A40, '{alu_nop, asel_rega, bsel_nop, dst_nop, wb_nop, fld_nop,
                1'b0, 1'b0, jmp_nonzero, jsrc_rel, imm_s7_0, st_nop}, 16'h0040, 3'd0);
        add_vec(16'h6085, '{alu_nop, asel_t, bsel_nop, dst_nop, wb_nop, fld_nop,
                1'b0, 1'b0, jmp_zero, jsrc_rel, imm_s7_0, st_nop}, 16'hFF85, 3'd0);  // BTEQZ.
        add_vec(16'hEB00, '{alu_reta, asel_rega, bsel_nop, dst_nop, wb_nop, fld_nop,
                1'b0, 1'b0, jmp_always, jsrc_alu, imm_none, st_nop}, 16'h0000, 3'd0); // JR.
        nop_vec(16'h0800);      // NOP itself.
        nop_vec(16'h1800);
        nop_vec(16'hF8FF);
        nop_vec(16'h80FF);
        nop_vec(16'h6100);      // Group1 with rx 001.
        nop_vec(16'hE000);
        nop_vec(16'hE002);
        nop_vec(16'hE801);
        nop_vec(16'hE820);      // Group3 sub-function zero with ry 001.
        nop_vec(16'h3001);
endtask

// File: sim/decode_tb.sv
`timescale 1ns/10ps

module decode_tb
        import mips16_pkg::*;
();

        logic        clk_50mhz;
        logic        rst_n;
        logic        in_valid;
        inst_word_u  inst;
        logic        out_valid;
        decode_out_s out;

        logic [15:0] vec_word[$];
        ctrl_s       vec_ctrl[$];
        logic [15:0] vec_imm[$];
        logic [2:0]  vec_wbr[$];
        ctrl_s       op_bundle [32];    // Expected bundle per operation, taken from the table.

        logic        exp_valid;
        decode_out_s exp_out;
        int          checks;
        int          errors;
        int          mark_checks;
        int          mark_errors;
        bit          done;

        decode_stage DUT (
                .clk_50mhz (clk_50mhz),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .inst      (inst),
                .out_valid (out_valid),
                .out       (out)
        );

        always #5 clk_50mhz = ~clk_50mhz;

        function automatic ctl_op_e ref_classify(input logic [15:0] w);
                ctl_op_e op;
                op = ctl_nop;
                case (w[15:11])
                        op_addsp3: op = ctl_addsp3;
                        op_b:      op = ctl_b;
                        op_beqz:   op = ctl_beqz;
                        op_bnez:   op = ctl_bnez;
                        op_addiu3: op = ctl_addiu3;
                        op_addiu:  op = ctl_addiu;
                        op_li:     op = ctl_li;
                        op_cmpi:   op = ctl_cmpi;
                        op_lw_sp:  op = ctl_lw_sp;
                        op_lw:     op = ctl_lw;
                        op_sw_sp:  op = ctl_sw_sp;
                        op_sw:     op = ctl_sw;
                        op_group1: begin
                                if (w[10:8] == 3'b011) op = ctl_addsp;
                                if (w[10:8] == 3'b000) op = ctl_bteqz;
                                if (w[10:8] == 3'b100) op = ctl_mtsp;
                                if (w[10:8] == 3'b010) op = ctl_sw_rs;
                        end
                        op_group2: begin
                                if (w[1:0] == 2'b01) op = ctl_addu;
                                if (w[1:0] == 2'b11) op = ctl_subu;
                        end
                        op_group3: begin
                                if (w[4:0] == 5'b01100) op = ctl_and;
                                if (w[4:0] == 5'b01010) op = ctl_cmp;
                                if (w[4:0] == 5'b01101) op = ctl_or;
                                if (w[4:0] == 5'b00100) op = ctl_sllv;
                                if (w[4:0] == 5'b00000 && w[7:5] == 3'b000) op = ctl_jr;
                                if (w[4:0] == 5'b00000 && w[7:5] == 3'b010) op = ctl_mfpc;
                        end
                        op_group4: op = w[0] ? ctl_mtih : ctl_mfih;
                        op_group5: begin
                                if (w[1:0] == 2'b00) op = ctl_sll;
                                if (w[1:0] == 2'b11) op = ctl_sra;
                                if (w[1:0] == 2'b10) op = ctl_srl;
                        end
                        default: op = ctl_nop;
                endcase
                return op;
        endfunction

        function automatic logic [15:0] ref_imm(input imm_fmt_e fmt, input logic [15:0] w);
                case (fmt)
                        imm_s3_0:  return {{12{w[3]}}, w[3:0]};
                        imm_s4_0:  return {{11{w[4]}}, w[4:0]};
                        imm_s7_0:  return {{8{w[7]}}, w[7:0]};
                        imm_z7_0:  return {8'h00, w[7:0]};
                        imm_s10_0: return {{5{w[10]}}, w[10:0]};
                        default:   return 16'h0000;
                endcase
        endfunction

        function automatic logic [2:0] ref_wb(input wb_field_e fld, input logic [15:0] w);
                case (fld)
                        fld_rx:  return w[10:8];
                        fld_ry:  return w[7:5];
                        fld_rz:  return w[4:2];
                        default: return 3'd0;
                endcase
        endfunction

        task automatic add_vec(input logic [15:0] w, input ctrl_s c, input logic [15:0] i,
                               input logic [2:0] r);
                vec_word.push_back(w);
                vec_ctrl.push_back(c);
                vec_imm.push_back(i);
                vec_wbr.push_back(r);
                op_bundle[ref_classify(w)] = c;
        endtask

        task automatic nop_vec(input logic [15:0] w);
                add_vec(w, ctrl_nop, 16'h0000, 3'd0);
        endtask

        `include "decode_vectors.svh"

        task automatic check_val(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
                end
        endtask

        task automatic check_outputs();
                check_val("out_valid", 32'(out_valid), 32'(exp_valid));
                check_val("out.ctrl", 32'(out.ctrl), 32'(exp_out.ctrl));
                check_val("out.imm", 32'(out.imm), 32'(exp_out.imm));
                check_val("out.wb_reg", 32'(out.wb_reg), 32'(exp_out.wb_reg));
        endtask

        // Checks the word driven one cycle earlier, then drives the next one.
        task automatic apply(input logic v, input logic [15:0] w, input decode_out_s e);
                @(negedge clk_50mhz);
                check_outputs();
                in_valid = v;
                inst = w;
                if (v) begin
                        exp_out = e;
                end
                exp_valid = v;
        endtask

        task automatic report_test(input string name);
                $display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
                         errors - mark_errors);
                mark_checks = checks;
                mark_errors = errors;
        endtask

        initial begin
                decode_out_s e;
                ctrl_s       c;
                logic [31:0] r;
                clk_50mhz = 1'b0;
                rst_n = 1'b0;
                in_valid = 1'b1;        // A valid load during reset must not reach the output.
                inst = 16'h9953;
                checks = 0;
                errors = 0;
                mark_checks = 0;
                mark_errors = 0;
                done = 1'b0;
                void'($urandom(90));
                load_vectors();
                repeat (8) begin
                        @(negedge clk_50mhz);
                        check_val("out_valid", 32'(out_valid), 32'd0);
                        check_val("out.ctrl.mem_en", 32'(out.ctrl.mem_en), 32'd0);
                end
                rst_n = 1'b1;
                in_valid = 1'b0;
                exp_valid = 1'b0;
                exp_out = '{ctrl: ctrl_nop, imm: '0, wb_reg: '0};
                @(negedge clk_50mhz);
                check_outputs();        // First edge after reset.
                report_test("reset");
                for (int i = 0; i < vec_word.size(); i++) begin
                        e = '{ctrl: vec_ctrl[i], imm: vec_imm[i], wb_reg: vec_wbr[i]};
                        apply(1'b1, vec_word[i], e);
                end
                report_test("directed table");
                for (int i = 0; i < 200; i++) begin
                        r = $urandom();
                        c = op_bundle[ref_classify(r[31:16])];
                        e = '{ctrl: c, imm: ref_imm(c.imm_fmt, r[31:16]),
                              wb_reg: ref_wb(c.wb_field, r[31:16])};
                        apply(r[0], r[31:16], e);
                end
                @(negedge clk_50mhz);
                check_outputs();
                report_test("random words and valid");
                $display("total: %0d checks, %0d errors", checks, errors);
                done = 1'b1;
                if (errors == 0) begin
                        $display("Simulation PASSED");
                end else begin
                        $display("Simulation FAILED");
                end
                $finish;
        end

        initial begin
                int limit;
                #1;
                limit = (vec_word.size() + 200 + 20) * 10;
                #(limit);
                if (!done) begin
                        $display("watchdog: the tests did not finish within %0d ns", limit);
                        $display("Simulation FAILED");
                        $finish;
                end
        end

endmodule

// File: mips16_decode.f
+incdir+include
src/mips16_pkg.sv
src/inst_classify.sv
src/ctrl_table.sv
src/operand_fields.sv
src/decode_stage.sv
sim/decode_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := decode_tb
FILELIST := mips16_decode.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(wildcard src/*.sv) $(wildcard sim/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
